//--- sim.f
+incdir+hdl
hdl/core_glue_pkg.sv
hdl/core_glue_ifs.sv
hdl/bridge_regs.sv
hdl/dataslot_ctrl.sv
hdl/pad_sync.sv
hdl/video_out_fmt.sv
hdl/core_glue_top.sv
tests/tb_clock_gen.sv
tests/core_glue_sva.sv
tests/tb_core_glue.sv

//--- Makefile
# Verilator build and run for the core glue testbench

SIM  := obj_dir/Vtb_core_glue
SRCS := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_core_glue -f sim.f

# a missing pass line counts as failure too, e.g. after an assertion stop
run: $(SIM)
	-$(SIM) > sim.log 2>&1
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tests/tb_core_glue.sv
////////////////////////////////////////
// testbench for the core glue top level
// table-driven checks of read mux, settings,
// sequencer, download levels, pads and video
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module tb_core_glue;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_TIMEOUT = 64;
  localparam int PAD_WORDS     = 40;
  localparam logic [31:0] CMD_WORD  = 32'hC3D0_0001;
  localparam logic [31:0] SAVE_WORD = 32'h5A7E_0002;

  // expected read and video pixel sources
  localparam logic [1:0] SEL_ZERO = 2'd0;
  localparam logic [1:0] SEL_CMD  = 2'd1;
  localparam logic [1:0] SEL_SAVE = 2'd2;
  localparam logic [1:0] OUT_ZERO = 2'd0;
  localparam logic [1:0] OUT_PIX  = 2'd1;
  localparam logic [1:0] OUT_SLOT = 2'd2;

  // key bit per core button from the msb down
  localparam int PAD_KEY_POS [12] = '{`KEY_A, `KEY_B, `KEY_X, `KEY_Y, `KEY_L, `KEY_R,
                                      `KEY_START, `KEY_SELECT, `KEY_UP, `KEY_DOWN,
                                      `KEY_LEFT, `KEY_RIGHT};

  ////////////////////////////////////////
  // stimulus tables

  typedef struct packed {
    logic [31:0] addr;
    logic [1:0]  sel;
  } mux_row_t;
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic        mt;
    logic        asp;
  } set_row_t;
  typedef struct packed {
    logic [3:0]  size;
    logic [31:0] q;
    logic [31:0] bytes;
  } seq_row_t;
  typedef struct packed {
    logic rr;
    logic rw;
    logic ac;
    logic io;
    logic sv;
  } dl_row_t;
  typedef struct packed {
    logic hb;
    logic vb;
    logic hs;
    logic vs;
    logic [23:0] rgb;
    logic de_x;
    logic hs_x;
    logic vs_x;
    logic [1:0] sel;
  } video_row_t;

  localparam mux_row_t MUX_TBL [5] = '{
    '{32'hF800_1234, SEL_CMD}, '{32'h2000_0010, SEL_SAVE}, '{32'h2FFF_FFFC, SEL_SAVE},
    '{32'h1000_0000, SEL_ZERO}, '{32'h0000_0100, SEL_ZERO}};

  // settings expected one cycle after each write
  localparam set_row_t SET_TBL [8] = '{
    '{`ADDR_MULTITAP, 32'h1, 1, 0}, '{`ADDR_ASPECT, 32'h1, 1, 1},
    '{32'h0000_0300, 32'h0, 1, 1}, '{`ADDR_MULTITAP, 32'h0, 0, 1},
    '{`ADDR_ASPECT, 32'h0, 0, 0}, '{32'h0000_0000, 32'h1, 0, 0},
    '{32'h0000_0201, 32'h1, 0, 0}, '{`ADDR_ASPECT, 32'hFFFF_FFFF, 0, 1}};

  // save-ram bytes are 1024 << code or zero for code zero
  localparam seq_row_t SEQ_TBL [3] = '{
    '{4'd0, 32'h0004_0000, 32'd0}, '{4'd1, 32'h0010_0000, 32'd2048},
    '{4'd5, 32'h0030_0000, 32'd32768}};

  localparam dl_row_t DL_TBL [13] = '{
    '{0, 0, 0, 0, 0}, '{0, 0, 1, 0, 0}, '{0, 1, 1, 1, 1}, '{0, 0, 1, 0, 1},
    '{0, 0, 1, 0, 1}, '{0, 0, 0, 0, 1}, '{0, 0, 1, 0, 0}, '{1, 0, 0, 0, 1},
    '{0, 0, 0, 0, 1}, '{0, 0, 1, 0, 0}, '{0, 1, 0, 1, 1}, '{0, 0, 0, 1, 1},
    '{0, 0, 1, 0, 0}};

  localparam video_row_t VIDEO_TBL [14] = '{
    '{1, 1, 0, 0, 24'h111111, 0, 0, 0, OUT_ZERO}, '{1, 1, 0, 1, 24'h222222, 0, 0, 1, OUT_ZERO},
    '{1, 1, 0, 1, 24'h333333, 0, 0, 0, OUT_ZERO}, '{1, 0, 1, 0, 24'h444444, 0, 1, 0, OUT_ZERO},
    '{1, 0, 1, 0, 24'h555555, 0, 0, 0, OUT_ZERO}, '{0, 0, 0, 0, 24'hA1B2C3, 1, 0, 0, OUT_PIX},
    '{0, 0, 0, 0, 24'hFFFFFF, 1, 0, 0, OUT_PIX}, '{0, 0, 0, 0, 24'h00FF00, 1, 0, 0, OUT_PIX},
    '{1, 0, 0, 0, 24'h123456, 0, 0, 0, OUT_SLOT}, '{1, 0, 0, 0, 24'h654321, 0, 0, 0, OUT_ZERO},
    '{0, 1, 0, 0, 24'h777777, 0, 0, 0, OUT_ZERO}, '{0, 0, 1, 0, 24'h0F0F0F, 1, 1, 0, OUT_PIX},
    '{0, 1, 0, 0, 24'h888888, 0, 0, 0, OUT_SLOT}, '{1, 1, 0, 0, 24'h999999, 0, 0, 0, OUT_ZERO}};

  ////////////////////////////////////////
  // DUT and clock

  logic                        clk_74a;
  logic                        pll_core_locked;
  core_glue_pkg::bridge_addr_t bridge_addr;
  logic                        bridge_rd;
  logic                        bridge_wr;
  core_glue_pkg::bridge_word_t bridge_wr_data;
  core_glue_pkg::bridge_word_t bridge_rd_data;
  core_glue_pkg::bridge_word_t cmd_rd_data;
  core_glue_pkg::bridge_word_t save_rd_data;
  logic                        dataslot_requestread;
  logic                        dataslot_requestwrite;
  logic                        dataslot_allcomplete;
  core_glue_pkg::bridge_word_t datatable_q;
  core_glue_pkg::dt_addr_t     datatable_addr;
  logic                        datatable_wren;
  core_glue_pkg::bridge_word_t datatable_data;
  core_glue_pkg::sram_size_t   sram_size;
  core_glue_pkg::bridge_word_t rom_file_size;
  logic                        ioctl_download;
  logic                        save_download;
  core_glue_pkg::cont_key_t    cont_key [`NUM_PADS];
  core_glue_pkg::snes_pad_t    pad_out [`NUM_PADS];
  logic                        multitap_enabled;
  logic                        use_4_3_video;
  logic                        src_hblank;
  logic                        src_vblank;
  logic                        src_hs;
  logic                        src_vs;
  logic                        pal;
  core_glue_pkg::rgb_t         src_rgb;
  logic                        video_de;
  logic                        video_hs;
  logic                        video_vs;
  core_glue_pkg::rgb_t         video_rgb;

  int          checks;
  int          errors;
  int          timeouts;
  logic        exp_aspect;
  logic [31:0] lfsr_state;
  logic [15:0] key_words [`NUM_PADS][PAD_WORDS];

  tb_clock_gen u_clk (.clk_74a(clk_74a), .pll_core_locked(pll_core_locked));

  core_glue_top dut0 (.*);

  ////////////////////////////////////////
  // helpers

  // move to 10 ns after the next rising edge
  task automatic step_cycle();
    @(posedge clk_74a);
    #10;
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_key(output logic [15:0] w);
    for (int b = 0; b < 16; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  function automatic logic [11:0] expected_pad(input logic [15:0] key);
    logic [11:0] p;
    for (int i = 0; i < 12; i++) p[11-i] = key[PAD_KEY_POS[i]];
    return p;
  endfunction

  task automatic init_inputs();
    bridge_addr = '0;
    bridge_rd = 1'b0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    cmd_rd_data = CMD_WORD;
    save_rd_data = SAVE_WORD;
    dataslot_requestread = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete = 1'b0;
    datatable_q = '0;
    sram_size = '0;
    for (int p = 0; p < `NUM_PADS; p++) cont_key[p] = '0;
    src_hblank = 1'b1;
    src_vblank = 1'b1;
    src_hs = 1'b0;
    src_vs = 1'b0;
    pal = 1'b0;
    src_rgb = '0;
  endtask

  task automatic wait_reset_release(output bit released);
    int n;
    n = 0;
    while (pll_core_locked !== 1'b1 && n < RESET_TIMEOUT) begin
      @(posedge clk_74a);
      n++;
    end
    released = (pll_core_locked === 1'b1);
    step_cycle();
  endtask

  // aspect bit carried into the next slot words
  task automatic write_aspect(input logic val);
    bridge_addr = `ADDR_ASPECT;
    bridge_wr_data = {31'd0, val};
    bridge_wr = 1'b1;
    step_cycle();
    bridge_wr = 1'b0;
    check("aspect before video line", use_4_3_video, val);
    exp_aspect = val;
  endtask

  ////////////////////////////////////////
  // behaviors

  task automatic read_mux_sweep();
    logic [31:0] exp;
    for (int i = 0; i < 5; i++) begin
      bridge_addr = MUX_TBL[i].addr;
      bridge_rd = 1'b1;
      step_cycle();
      case (MUX_TBL[i].sel)
        SEL_CMD:  exp = CMD_WORD;
        SEL_SAVE: exp = SAVE_WORD;
        default:  exp = '0;
      endcase
      check($sformatf("read data at %h", MUX_TBL[i].addr), bridge_rd_data, exp);
    end
    bridge_rd = 1'b0;
  endtask

  task automatic settings_writes();
    for (int i = 0; i < 8; i++) begin
      bridge_addr = SET_TBL[i].addr;
      bridge_wr_data = SET_TBL[i].data;
      bridge_wr = 1'b1;
      step_cycle();
      bridge_wr = 1'b0;
      check($sformatf("multitap after write %0d", i), multitap_enabled, SET_TBL[i].mt);
      check($sformatf("aspect after write %0d", i), use_4_3_video, SET_TBL[i].asp);
      exp_aspect = SET_TBL[i].asp;
    end
  endtask

  task automatic sequencer_window();
    int wren_cycles;
    for (int i = 0; i < 3; i++) begin
      sram_size = SEQ_TBL[i].size;
      datatable_q = SEQ_TBL[i].q;
      // one full period so every phase sees the new inputs
      repeat (8) step_cycle();
      check($sformatf("rom_file_size entry %0d", i), rom_file_size, SEQ_TBL[i].q);
      wren_cycles = 0;
      for (int c = 0; c < 16; c++) begin
        step_cycle();
        if (datatable_wren === 1'b1) begin
          wren_cycles++;
          check("datatable_addr on write", datatable_addr, `DT_SRAM_SIZE_ADDR);
          check($sformatf("save-ram size entry %0d", i), datatable_data, SEQ_TBL[i].bytes);
        end else begin
          check("datatable_addr on read", datatable_addr, `DT_ROM_SIZE_ADDR);
        end
      end
      check($sformatf("wren cycles entry %0d", i), wren_cycles, 6);
    end
  endtask

  task automatic download_levels();
    for (int i = 0; i < 13; i++) begin
      dataslot_requestread = DL_TBL[i].rr;
      dataslot_requestwrite = DL_TBL[i].rw;
      dataslot_allcomplete = DL_TBL[i].ac;
      step_cycle();
      check($sformatf("ioctl_download row %0d", i), ioctl_download, DL_TBL[i].io);
      check($sformatf("save_download row %0d", i), save_download, DL_TBL[i].sv);
    end
    dataslot_allcomplete = 1'b0;
  endtask

  task automatic pad_stream();
    logic [11:0] exp;
    for (int p = 0; p < `NUM_PADS; p++) begin
      for (int w = 0; w < PAD_WORDS; w++) random_key(key_words[p][w]);
    end
    // each word shows up three cycles after it is driven
    for (int c = 0; c < PAD_WORDS + 2; c++) begin
      for (int p = 0; p < `NUM_PADS; p++) begin
        cont_key[p] = (c < PAD_WORDS) ? key_words[p][c] : 16'h0;
      end
      step_cycle();
      for (int p = 0; p < `NUM_PADS; p++) begin
        if (c >= 2) exp = expected_pad(key_words[p][c-2]);
        else exp = '0;
        check($sformatf("pad %0d word %0d", p, c - 2), pad_out[p], exp);
      end
    end
  endtask

  task automatic video_line(input logic pal_val);
    logic [23:0] slot;
    logic [23:0] exp_rgb;
    slot = '0;
    slot[`SLOT_PAL_BIT] = pal_val;
    slot[`SLOT_ASPECT_BIT] = exp_aspect;
    pal = pal_val;
    for (int r = 0; r < 14; r++) begin
      src_hblank = VIDEO_TBL[r].hb;
      src_vblank = VIDEO_TBL[r].vb;
      src_hs = VIDEO_TBL[r].hs;
      src_vs = VIDEO_TBL[r].vs;
      src_rgb = VIDEO_TBL[r].rgb;
      step_cycle();
      case (VIDEO_TBL[r].sel)
        OUT_PIX:  exp_rgb = VIDEO_TBL[r].rgb;
        OUT_SLOT: exp_rgb = slot;
        default:  exp_rgb = '0;
      endcase
      check($sformatf("video_de row %0d", r), video_de, VIDEO_TBL[r].de_x);
      check($sformatf("video_hs row %0d", r), video_hs, VIDEO_TBL[r].hs_x);
      check($sformatf("video_vs row %0d", r), video_vs, VIDEO_TBL[r].vs_x);
      check($sformatf("video_rgb row %0d pal %0b", r, pal_val), video_rgb, exp_rgb);
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    bit released;
    checks = 0;
    errors = 0;
    timeouts = 0;
    exp_aspect = 1'b0;
    lfsr_state = 32'hde1;
    init_inputs();
    wait_reset_release(released);
    if (released) begin
      read_mux_sweep();
      settings_writes();
      sequencer_window();
      download_levels();
      pad_stream();
      video_line(1'b1);
      video_line(1'b0);
      write_aspect(1'b0);
      video_line(1'b1);
    end else begin
      timeouts++;
      $display("timeout: pll_core_locked never went high");
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/core_glue_sva.sv
////////////////////////////////////////
// assertions on the core glue top level
// sync pulse width, wren burst, reset state
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module core_glue_sva (
  input wire                             clk_74a,
  input wire                             pll_core_locked,
  input wire                             multitap_enabled,
  input wire                             use_4_3_video,
  input wire                             ioctl_download,
  input wire                             save_download,
  input wire                             datatable_wren,
  input wire core_glue_pkg::dt_addr_t    datatable_addr,
  input wire core_glue_pkg::bridge_word_t datatable_data,
  input wire core_glue_pkg::bridge_word_t rom_file_size,
  input wire                             video_de,
  input wire                             video_hs,
  input wire                             video_vs,
  input wire core_glue_pkg::rgb_t        video_rgb,
  input wire core_glue_pkg::snes_pad_t   pad_out [`NUM_PADS]
);
  timeunit 1ns;
  timeprecision 100ps;

  // sync outputs are single-cycle pulses
  hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs) else $error("video_hs high for more than one cycle");

  vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs) else $error("video_vs high for more than one cycle");

  ////////////////////////////////////////
  // data-table writes

  wren_addr: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_wren |-> datatable_addr == `DT_SRAM_SIZE_ADDR)
    else $error("datatable write to the wrong address");

  // three write cycles per period
  wren_burst: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $fell(datatable_wren) |->
      $past(datatable_wren, 2) && $past(datatable_wren, 3) && !$past(datatable_wren, 4))
    else $error("datatable_wren burst is not three cycles long");

  ////////////////////////////////////////
  // reset state

  reset_clear: assert property (@(posedge clk_74a)
    !pll_core_locked |=>
      {multitap_enabled, use_4_3_video, ioctl_download, save_download,
       datatable_wren, datatable_addr, datatable_data, rom_file_size,
       video_de, video_hs, video_vs, video_rgb} == '0 &&
      pad_out[0] == '0 && pad_out[1] == '0 && pad_out[2] == '0 && pad_out[3] == '0)
    else $error("outputs not cleared during reset");

endmodule

bind core_glue_top core_glue_sva u_sva (
  .clk_74a          (clk_74a),
  .pll_core_locked  (pll_core_locked),
  .multitap_enabled (multitap_enabled),
  .use_4_3_video    (use_4_3_video),
  .ioctl_download   (ioctl_download),
  .save_download    (save_download),
  .datatable_wren   (datatable_wren),
  .datatable_addr   (datatable_addr),
  .datatable_data   (datatable_data),
  .rom_file_size    (rom_file_size),
  .video_de         (video_de),
  .video_hs         (video_hs),
  .video_vs         (video_vs),
  .video_rgb        (video_rgb),
  .pad_out          (pad_out)
);

`default_nettype wire

//--- tests/tb_clock_gen.sv
////////////////////////////////////////
// testbench clock and reset source
// 100 ns clock, reset low for 16 cycles
////////////////////////////////////////

`default_nettype none

module tb_clock_gen (
  output logic clk_74a,
  output logic pll_core_locked
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_74a = 1'b0;
    forever #50 clk_74a = ~clk_74a;
  end

  // release away from the clock edge
  initial begin
    pll_core_locked = 1'b0;
    repeat (16) @(posedge clk_74a);
    #10 pll_core_locked = 1'b1;
  end

endmodule

`default_nettype wire

//--- hdl/core_glue_top.sv
////////////////////////////////////////
// core glue top level
// bridge settings, data slots, pad sync
// and video output formatting
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module core_glue_top (
  input  wire                              clk_74a,
  input  wire                              pll_core_locked,

  // host bridge
  input  wire  core_glue_pkg::bridge_addr_t bridge_addr,
  input  wire                               bridge_rd,
  input  wire                               bridge_wr,
  input  wire  core_glue_pkg::bridge_word_t bridge_wr_data,
  output core_glue_pkg::bridge_word_t       bridge_rd_data,
  input  wire  core_glue_pkg::bridge_word_t cmd_rd_data,
  input  wire  core_glue_pkg::bridge_word_t save_rd_data,

  // data slots
  input  wire                               dataslot_requestread,
  input  wire                               dataslot_requestwrite,
  input  wire                               dataslot_allcomplete,
  input  wire  core_glue_pkg::bridge_word_t datatable_q,
  output core_glue_pkg::dt_addr_t           datatable_addr,
  output logic                              datatable_wren,
  output core_glue_pkg::bridge_word_t       datatable_data,
  input  wire  core_glue_pkg::sram_size_t   sram_size,
  output core_glue_pkg::bridge_word_t       rom_file_size,
  output logic                              ioctl_download,
  output logic                              save_download,

  // controllers
  input  wire  core_glue_pkg::cont_key_t    cont_key [`NUM_PADS],
  output core_glue_pkg::snes_pad_t          pad_out [`NUM_PADS],

  // settings
  output logic                              multitap_enabled,
  output logic                              use_4_3_video,

  // video
  input  wire                               src_hblank,
  input  wire                               src_vblank,
  input  wire                               src_hs,
  input  wire                               src_vs,
  input  wire                               pal,
  input  wire  core_glue_pkg::rgb_t         src_rgb,
  output logic                              video_de,
  output logic                              video_hs,
  output logic                              video_vs,
  output core_glue_pkg::rgb_t               video_rgb
);

  ////////////////////////////////////////
  // bus wrapping

  bridge_bus_if bus ();
  video_src_if  vsrc ();

  assign bus.addr       = bridge_addr;
  assign bus.rd         = bridge_rd;
  assign bus.wr         = bridge_wr;
  assign bus.wr_data    = bridge_wr_data;
  assign bridge_rd_data = bus.rd_data;

  assign vsrc.hblank = src_hblank;
  assign vsrc.vblank = src_vblank;
  assign vsrc.hs     = src_hs;
  assign vsrc.vs     = src_vs;
  assign vsrc.rgb    = src_rgb;

  ////////////////////////////////////////
  // blocks

  bridge_regs u_bridge_regs (
    .clk_74a          (clk_74a),
    .pll_core_locked  (pll_core_locked),
    .bus              (bus.target),
    .cmd_rd_data      (cmd_rd_data),
    .save_rd_data     (save_rd_data),
    .multitap_enabled (multitap_enabled),
    .use_4_3_video    (use_4_3_video)
  );

  dataslot_ctrl u_dataslot_ctrl (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .ioctl_download        (ioctl_download),
    .save_download         (save_download),
    .sram_size             (sram_size),
    .datatable_q           (datatable_q),
    .datatable_addr        (datatable_addr),
    .datatable_wren        (datatable_wren),
    .datatable_data        (datatable_data),
    .rom_file_size         (rom_file_size)
  );

  // one synchroniser per controller
  for (genvar i = 0; i < `NUM_PADS; i++) begin : g_pad
    pad_sync u_pad_sync (
      .clk_74a         (clk_74a),
      .pll_core_locked (pll_core_locked),
      .key             (cont_key[i]),
      .pad             (pad_out[i])
    );
  end

  video_out_fmt u_video_out_fmt (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .src             (vsrc.sink),
    .pal             (pal),
    .use_4_3_video   (use_4_3_video),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

`default_nettype wire

//--- hdl/video_out_fmt.sv
////////////////////////////////////////
// video output formatter
// registered de, sync pulses, pixel data
// and the end-of-line slot word
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module video_out_fmt (
  input  wire                 clk_74a,
  input  wire                 pll_core_locked,
  video_src_if.sink           src,
  input  wire                 pal,
  input  wire                 use_4_3_video,
  output logic                video_de,
  output logic                video_hs,
  output logic                video_vs,
  output core_glue_pkg::rgb_t video_rgb
);

  logic                de;
  logic                de_prev;
  logic                hs_prev;
  logic                vs_prev;
  core_glue_pkg::rgb_t slot_word;

  assign de = !(src.hblank || src.vblank);

  // flags for the scaler, everything else stays zero
  always_comb begin
    slot_word                   = '0;
    slot_word[`SLOT_PAL_BIT]    = pal;
    slot_word[`SLOT_ASPECT_BIT] = use_4_3_video;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end else begin
      de_prev <= de;
      hs_prev <= src.hs;
      vs_prev <= src.vs;

      video_de <= de;
      // one-cycle pulse on the source sync rising edge
      video_hs <= src.hs && !hs_prev;
      video_vs <= src.vs && !vs_prev;

      if (de) video_rgb <= src.rgb;
      else if (de_prev) video_rgb <= slot_word;
      else video_rgb <= '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pad_sync.sv
////////////////////////////////////////
// controller key synchroniser
// with reorder into core button order
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module pad_sync #(
  parameter int STAGES = `PAD_SYNC_STAGES
) (
  input  wire                             clk_74a,
  input  wire                             pll_core_locked,
  input  wire  core_glue_pkg::cont_key_t  key,
  output core_glue_pkg::snes_pad_t        pad
);

  core_glue_pkg::cont_key_t sync_q [STAGES];
  core_glue_pkg::cont_key_t key_s;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int i = 0; i < STAGES; i++) sync_q[i] <= '0;
    end else begin
      sync_q[0] <= key;
      for (int i = 1; i < STAGES; i++) sync_q[i] <= sync_q[i-1];
    end
  end

  assign key_s = sync_q[STAGES-1];

  // a b x y l r start select up down left right
  assign pad = {key_s[`KEY_A], key_s[`KEY_B], key_s[`KEY_X], key_s[`KEY_Y],
                key_s[`KEY_L], key_s[`KEY_R], key_s[`KEY_START], key_s[`KEY_SELECT],
                key_s[`KEY_UP], key_s[`KEY_DOWN], key_s[`KEY_LEFT], key_s[`KEY_RIGHT]};

endmodule

`default_nettype wire

//--- hdl/dataslot_ctrl.sv
////////////////////////////////////////
// data-slot download levels and the
// data-table size sequencer
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module dataslot_ctrl (
  input  wire                               clk_74a,
  input  wire                               pll_core_locked,
  input  wire                               dataslot_requestread,
  input  wire                               dataslot_requestwrite,
  input  wire                               dataslot_allcomplete,
  output logic                              ioctl_download,
  output logic                              save_download,
  input  wire  core_glue_pkg::sram_size_t   sram_size,
  input  wire  core_glue_pkg::bridge_word_t datatable_q,
  output core_glue_pkg::dt_addr_t           datatable_addr,
  output logic                              datatable_wren,
  output core_glue_pkg::bridge_word_t       datatable_data,
  output core_glue_pkg::bridge_word_t       rom_file_size
);

  logic                        allcomplete_prev;
  core_glue_pkg::dt_phase_t    phase;
  core_glue_pkg::dt_state_t    state;
  core_glue_pkg::bridge_word_t sram_bytes;

  ////////////////////////////////////////
  // download levels

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      ioctl_download   <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;

      if (dataslot_requestwrite) ioctl_download <= 1'b1;
      else if (dataslot_allcomplete) ioctl_download <= 1'b0;

      // save level only clears on a fresh allcomplete edge
      if (dataslot_requestread || dataslot_requestwrite) save_download <= 1'b1;
      else if (dataslot_allcomplete && !allcomplete_prev) save_download <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // size sequencer

  // last three phases of eight write the save-ram size
  assign state = (phase >= `DT_WRITE_FIRST_PHASE) ? core_glue_pkg::DT_WRITE_SRAM
                                                  : core_glue_pkg::DT_READ_ROM;

  // size code from the rom header, zero means no save ram
  assign sram_bytes = (sram_size == '0) ? '0 : (`SRAM_UNIT_BYTES << sram_size);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase          <= '0;
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
      datatable_data <= '0;
      rom_file_size  <= '0;
    end else begin
      phase <= phase + 1'b1;
      case (state)
        core_glue_pkg::DT_WRITE_SRAM: begin
          datatable_wren <= 1'b1;
          datatable_addr <= `DT_SRAM_SIZE_ADDR;
          datatable_data <= sram_bytes;
        end
        default: begin
          datatable_wren <= 1'b0;
          datatable_addr <= `DT_ROM_SIZE_ADDR;
          // q has settled on the rom size slot by now
          if (phase == `DT_CAPTURE_PHASE) rom_file_size <= datatable_q;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/bridge_regs.sv
////////////////////////////////////////
// bridge settings registers
// and the bridge read-data mux
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

module bridge_regs (
  input  wire                               clk_74a,
  input  wire                               pll_core_locked,
  bridge_bus_if.target                      bus,
  input  wire  core_glue_pkg::bridge_word_t cmd_rd_data,
  input  wire  core_glue_pkg::bridge_word_t save_rd_data,
  output logic                              multitap_enabled,
  output logic                              use_4_3_video
);

  ////////////////////////////////////////
  // settings

  // only bit 0 of the write word matters
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      multitap_enabled <= 1'b0;
      use_4_3_video    <= 1'b0;
    end else if (bus.wr) begin
      case (bus.addr)
        `ADDR_MULTITAP: multitap_enabled <= bus.wr_data[0];
        `ADDR_ASPECT:   use_4_3_video    <= bus.wr_data[0];
        default:        ;
      endcase
    end
  end

  ////////////////////////////////////////
  // read mux

  always_comb begin
    bus.rd_data = '0;
    // command handler space
    if (bus.addr[31:24] == `RD_CMD_TOP) begin
      bus.rd_data = cmd_rd_data;
    end
    // save unloader, checked last so it takes priority
    if (bus.addr[31:28] == `RD_SAVE_TOP) begin
      bus.rd_data = save_rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/core_glue_ifs.sv
////////////////////////////////////////
// bridge_bus_if: host bridge bus
// video_src_if: video from the core side
////////////////////////////////////////

`default_nettype none

// no handshake, wr is a single-cycle strobe
interface bridge_bus_if;
  core_glue_pkg::bridge_addr_t addr;
  logic                        rd;
  logic                        wr;
  core_glue_pkg::bridge_word_t wr_data;
  core_glue_pkg::bridge_word_t rd_data;

  modport host (
    output addr, rd, wr, wr_data,
    input  rd_data
  );

  // rd_data follows addr with no latency
  modport target (
    input  addr, rd, wr, wr_data,
    output rd_data
  );
endinterface

interface video_src_if;
  logic                hblank;
  logic                vblank;
  logic                hs;
  logic                vs;
  core_glue_pkg::rgb_t rgb;

  modport src  (output hblank, vblank, hs, vs, rgb);
  modport sink (input  hblank, vblank, hs, vs, rgb);
endinterface

`default_nettype wire

//--- hdl/core_glue_pkg.sv
////////////////////////////////////////
// shared types of the core glue logic
// vector typedefs and the sequencer state
////////////////////////////////////////

`default_nettype none

`include "core_glue_macros.svh"

package core_glue_pkg;

  // bridge side
  typedef logic [`BRIDGE_WIDTH-1:0] bridge_addr_t;
  typedef logic [`BRIDGE_WIDTH-1:0] bridge_word_t;

  // raw host key bitmap
  typedef logic [`KEY_WIDTH-1:0] cont_key_t;

  // core button order, msb first:
  // a b x y l r start select up down left right
  typedef logic [`PAD_WIDTH-1:0] snes_pad_t;

  typedef logic [`RGB_WIDTH-1:0] rgb_t;

  // data-table access
  typedef logic [`DT_ADDR_WIDTH-1:0]   dt_addr_t;
  typedef logic [`SRAM_SIZE_WIDTH-1:0] sram_size_t;
  typedef logic [`DT_PHASE_WIDTH-1:0]  dt_phase_t;

  // what the sequencer does in the current phase
  typedef enum logic {
    DT_READ_ROM   = 1'b0,
    DT_WRITE_SRAM = 1'b1
  } dt_state_t;

endpackage

`default_nettype wire

//--- hdl/core_glue_macros.svh
////////////////////////////////////////
// constants for the core glue logic
// bridge addresses, widths, sequencer counts,
// slot-word bits and controller key positions
////////////////////////////////////////
`ifndef CORE_GLUE_MACROS_SVH
`define CORE_GLUE_MACROS_SVH

// vector widths
`define BRIDGE_WIDTH     32
`define KEY_WIDTH        16
`define PAD_WIDTH        12
`define RGB_WIDTH        24
`define DT_ADDR_WIDTH    10
`define SRAM_SIZE_WIDTH  4
`define DT_PHASE_WIDTH   3

// settings registers and read mux prefixes
`define ADDR_MULTITAP    32'h0000_0100
`define ADDR_ASPECT      32'h0000_0200
`define RD_CMD_TOP       8'hF8
`define RD_SAVE_TOP      4'h2

// data-table sequencer
`define DT_ROM_SIZE_ADDR     10'd1
`define DT_SRAM_SIZE_ADDR    10'd3
`define DT_CAPTURE_PHASE     3'd4
`define DT_WRITE_FIRST_PHASE 3'd5
`define SRAM_UNIT_BYTES      32'd1024

// end-of-line slot word
`define SLOT_PAL_BIT     14
`define SLOT_ASPECT_BIT  13

// host key bitmap positions
`define KEY_UP           0
`define KEY_DOWN         1
`define KEY_LEFT         2
`define KEY_RIGHT        3
`define KEY_A            4
`define KEY_B            5
`define KEY_X            6
`define KEY_Y            7
`define KEY_L            8
`define KEY_R            9
`define KEY_SELECT       14
`define KEY_START        15

// controller sync
`define PAD_SYNC_STAGES  3
`define NUM_PADS         4

`endif
